/* ipu.f */
hdl/ipu_pkg.sv
hdl/ipu_dispatch.sv
hdl/ipu_imadd.sv
hdl/ipu_lerp.sv
hdl/ipu_fifo.sv
hdl/ipu_commit.sv
hdl/ipu_top.sv
sim/tb_ipu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tb_ipu
FILELIST  := ipu.f

OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
SRCS   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -qx 'Done: no errors' $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/tb_ipu.sv */
// interpolation unit testbench
module tb_ipu;

    localparam int     NUM_REQ    = 400;
    localparam int     CLK_PERIOD = 20;
    localparam longint WATCHDOG   = longint'(NUM_REQ) * (ipu_pkg::LAT_IMADD + 40) * CLK_PERIOD;

    typedef struct packed {
        logic [ipu_pkg::NW_BITS-1:0]   wid;
        logic [ipu_pkg::NUM_LANES-1:0] tmask;
        logic [ipu_pkg::NR_BITS-1:0]   rd;
        logic                          wb;
        ipu_pkg::lane_data_t           data;
    } expect_t;

    logic clk;
    logic arst_n;
    logic in_valid;
    logic [ipu_pkg::OP_BITS-1:0]   in_op;
    logic [ipu_pkg::NW_BITS-1:0]   in_wid;
    logic [ipu_pkg::NUM_LANES-1:0] in_tmask;
    logic [ipu_pkg::NR_BITS-1:0]   in_rd;
    logic                          in_wb;
    ipu_pkg::lane_data_t           in_a, in_b, in_c;
    logic                          issue_credit;
    logic                          out_valid;
    logic [ipu_pkg::NW_BITS-1:0]   out_wid;
    logic [ipu_pkg::NUM_LANES-1:0] out_tmask;
    logic [ipu_pkg::NR_BITS-1:0]   out_rd;
    logic                          out_wb;
    ipu_pkg::lane_data_t           out_data;
    logic                          wb_credit;

    expect_t     exp_q[$];
    logic [31:0] rng_state = 32'h5dbd;
    int issued     = 0;
    int received   = 0;
    int credits    = ipu_pkg::ISSUE_CREDITS;  // issue credits held by the issuer
    int wb_held    = ipu_pkg::WB_CREDITS;     // writeback credits held by the DUT
    bit wb_started = 0;
    int mismatches = 0;
    int errors     = 0;

    ipu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // corner values show up often enough to matter
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[31:29])
            3'd0:    return 32'd0;
            3'd1:    return 32'hffff_ffff;
            default: return next_rand();
        endcase
    endfunction

    function automatic logic [31:0] pick_weight();
        logic [31:0] r;
        r = next_rand();
        case (r[31:29])
            3'd0:    return {r[15:0], 16'h0000};  // upper half is ignored by the unit
            3'd1:    return {r[15:0], 16'hffff};
            3'd2:    return 32'h0000_8000;
            default: return next_rand();
        endcase
    endfunction

    // reference model of one lane
    function automatic logic [31:0] lane_model(logic [1:0] op, logic [31:0] a, logic [31:0] b,
                                               logic [31:0] c);
        logic [63:0] full;
        logic [31:0] d32;
        longint      diff;
        longint      t;
        longint      scaled;
        full   = {32'd0, a} * {32'd0, b};
        d32    = b - a;
        diff   = longint'($signed(d32));
        t      = longint'({48'd0, c[15:0]});
        scaled = (diff * t) >>> 16;
        case (op)
            ipu_pkg::OP_MUL_LO: return full[31:0] + c;
            ipu_pkg::OP_MUL_HI: return full[63:32] + c;
            default:            return a + scaled[31:0];
        endcase
    endfunction

    task automatic check_idle(input string phase);
        if (out_valid !== 1'b0 || issue_credit !== 1'b0) begin
            $display("error at %0t: out_valid or issue_credit high %s", $time, phase);
            errors++;
        end
    endtask

    task automatic compare_result(input expect_t e);
        if (out_wid !== e.wid || out_tmask !== e.tmask || out_rd !== e.rd || out_wb !== e.wb) begin
            $display("mismatch at %0t: wid %0d tmask %b rd %0d wb %b, expected %0d %b %0d %b",
                     $time, out_wid, out_tmask, out_rd, out_wb, e.wid, e.tmask, e.rd, e.wb);
            mismatches++;
        end
        for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
            if (out_data[i] !== e.data[i]) begin
                $display("mismatch at %0t: lane %0d data %h, expected %h",
                         $time, i, out_data[i], e.data[i]);
                mismatches++;
            end
        end
    endtask

    // outputs are stable at the falling edge, ahead of the next rising edge
    task automatic sample_outputs();
        if (issue_credit !== out_valid) begin
            $display("mismatch at %0t: issue_credit %b with out_valid %b",
                     $time, issue_credit, out_valid);
            mismatches++;
        end
        if (out_valid === 1'b1) begin
            if (wb_held == 0) begin
                $display("error at %0t: out_valid while the DUT holds no writeback credit", $time);
                errors++;
            end else begin
                wb_held--;
            end
            if (exp_q.size() == 0) begin
                $display("error at %0t: result arrived with no request outstanding", $time);
                errors++;
            end else begin
                compare_result(exp_q.pop_front());
            end
            received++;
        end
        if (issue_credit === 1'b1) credits++;
    endtask

    task automatic drive_wb_credit();
        logic [31:0] r;
        r = next_rand();
        wb_credit = 1'b0;
        // the first credit waits until the reset credits are used up
        if (wb_held < ipu_pkg::WB_CREDITS && (wb_started || wb_held == 0) && r[31:30] != 2'd0) begin
            if (!wb_started && received != ipu_pkg::WB_CREDITS) begin
                $display("error at %0t: %0d results came out before the first writeback credit",
                         $time, received);
                errors++;
            end
            wb_started = 1;
            wb_credit  = 1'b1;
            wb_held++;
        end
    endtask

    task automatic drive_issue();
        logic [31:0] r;
        logic [31:0] m;
        expect_t     e;
        r = next_rand();
        in_valid = 1'b0;
        if (issued < NUM_REQ && credits > 0 && r[31:29] != 3'd0) begin
            in_op = ipu_pkg::OP_BITS'(r[15:0] % 16'd3);
            m = next_rand();
            in_wid   = m[2:0];
            in_tmask = m[7:4];
            in_rd    = m[12:8];
            in_wb    = m[16];
            for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
                in_a[i] = pick_operand();
                in_b[i] = pick_operand();
                in_c[i] = (in_op == ipu_pkg::OP_LERP) ? pick_weight() : pick_operand();
                e.data[i] = lane_model(in_op, in_a[i], in_b[i], in_c[i]);
            end
            e.wid   = in_wid;
            e.tmask = in_tmask;
            e.rd    = in_rd;
            e.wb    = in_wb;
            exp_q.push_back(e);
            in_valid = 1'b1;
            credits--;
            issued++;
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_op     = '0;
        in_wid    = '0;
        in_tmask  = '0;
        in_rd     = '0;
        in_wb     = 1'b0;
        in_a      = '0;
        in_b      = '0;
        in_c      = '0;
        wb_credit = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle("during reset");
        end
        arst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("right after reset");
        end
        while (received < NUM_REQ) begin
            @(negedge clk);
            sample_outputs();
            drive_wb_credit();
            drive_issue();
        end
        repeat (10) begin  // nothing more may come out
            @(negedge clk);
            sample_outputs();
            drive_wb_credit();
            drive_issue();
        end
        if (credits != ipu_pkg::ISSUE_CREDITS) begin
            $display("error: issuer ends with %0d issue credits instead of %0d",
                     credits, ipu_pkg::ISSUE_CREDITS);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("error: %0d requests never produced a result", exp_q.size());
            errors++;
        end
        $display("results %0d of %0d, mismatches %0d, other errors %0d",
                 received, NUM_REQ, mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* hdl/ipu_top.sv */
// interpolation execution unit
module ipu_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  logic [ipu_pkg::OP_BITS-1:0]   in_op,
    input  logic [ipu_pkg::NW_BITS-1:0]   in_wid,
    input  logic [ipu_pkg::NUM_LANES-1:0] in_tmask,
    input  logic [ipu_pkg::NR_BITS-1:0]   in_rd,
    input  logic                          in_wb,
    input  ipu_pkg::lane_data_t           in_a,
    input  ipu_pkg::lane_data_t           in_b,
    input  ipu_pkg::lane_data_t           in_c,
    output logic                          issue_credit,
    output logic                          out_valid,
    output logic [ipu_pkg::NW_BITS-1:0]   out_wid,
    output logic [ipu_pkg::NUM_LANES-1:0] out_tmask,
    output logic [ipu_pkg::NR_BITS-1:0]   out_rd,
    output logic                          out_wb,
    output ipu_pkg::lane_data_t           out_data,
    input  logic                          wb_credit
);

    logic                         imadd_valid, imadd_hi, lerp_valid;
    logic [ipu_pkg::SEQ_BITS-1:0] seq;

    logic                imadd_res_valid, lerp_res_valid;
    ipu_pkg::imadd_res_t imadd_res;
    ipu_pkg::lerp_res_t  lerp_res;

    ipu_dispatch u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .credit_ret  (issue_credit),
        .imadd_valid (imadd_valid),
        .imadd_hi    (imadd_hi),
        .lerp_valid  (lerp_valid),
        .seq         (seq)
    );

    ipu_imadd u_imadd (
        .clk (clk), .arst_n (arst_n),
        .req_valid (imadd_valid), .req_hi (imadd_hi), .req_seq (seq),
        .req_wid (in_wid), .req_tmask (in_tmask), .req_rd (in_rd), .req_wb (in_wb),
        .a (in_a), .b (in_b), .c (in_c),
        .res_valid (imadd_res_valid), .res (imadd_res)
    );

    // lerp reads its weight from the low half of in_c
    ipu_lerp u_lerp (
        .clk (clk), .arst_n (arst_n),
        .req_valid (lerp_valid), .req_seq (seq),
        .req_wid (in_wid), .req_tmask (in_tmask), .req_rd (in_rd), .req_wb (in_wb),
        .a (in_a), .b (in_b), .c (in_c),
        .res_valid (lerp_res_valid), .res (lerp_res)
    );

    ipu_commit u_commit (
        .clk (clk), .arst_n (arst_n),
        .imadd_res_valid (imadd_res_valid), .imadd_res (imadd_res),
        .lerp_res_valid (lerp_res_valid), .lerp_res (lerp_res),
        .wb_credit (wb_credit),
        .out_valid (out_valid), .out_wid (out_wid), .out_tmask (out_tmask),
        .out_rd (out_rd), .out_wb (out_wb), .out_data (out_data),
        .issue_credit (issue_credit)
    );

endmodule

/* hdl/ipu_commit.sv */
// in-order commit stage
module ipu_commit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          imadd_res_valid,
    input  ipu_pkg::imadd_res_t           imadd_res,
    input  logic                          lerp_res_valid,
    input  ipu_pkg::lerp_res_t            lerp_res,
    input  logic                          wb_credit,
    output logic                          out_valid,
    output logic [ipu_pkg::NW_BITS-1:0]   out_wid,
    output logic [ipu_pkg::NUM_LANES-1:0] out_tmask,
    output logic [ipu_pkg::NR_BITS-1:0]   out_rd,
    output logic                          out_wb,
    output ipu_pkg::lane_data_t           out_data,
    output logic                          issue_credit
);

    ipu_pkg::imadd_res_t m_head;
    ipu_pkg::lerp_res_t  l_head;

    logic m_empty, l_empty;
    logic m_hit, l_hit, pop_m, pop_l;
    logic have_credit;

    logic [ipu_pkg::SEQ_BITS-1:0]    exp_seq;
    logic [ipu_pkg::WB_CNT_BITS-1:0] wb_cnt;

    ipu_fifo #(.T(ipu_pkg::imadd_res_t), .DEPTH(ipu_pkg::ISSUE_CREDITS)) u_imadd_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (imadd_res_valid),
        .push_data (imadd_res),
        .pop       (pop_m),
        .head      (m_head),
        .empty     (m_empty),
        .full      ()
    );

    ipu_fifo #(.T(ipu_pkg::lerp_res_t), .DEPTH(ipu_pkg::ISSUE_CREDITS)) u_lerp_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (lerp_res_valid),
        .push_data (lerp_res),
        .pop       (pop_l),
        .head      (l_head),
        .empty     (l_empty),
        .full      ()
    );

    assign have_credit = (wb_cnt != '0);
    assign m_hit       = !m_empty && (m_head.seq == exp_seq);
    assign l_hit       = !l_empty && (l_head.seq == exp_seq);
    assign pop_m       = m_hit && have_credit;
    assign pop_l       = l_hit && have_credit && !m_hit;

    assign out_valid    = pop_m || pop_l;
    assign issue_credit = out_valid;  // one slot frees up per retired result
    assign out_wid      = pop_m ? m_head.wid   : l_head.wid;
    assign out_tmask    = pop_m ? m_head.tmask : l_head.tmask;
    assign out_rd       = pop_m ? m_head.rd    : l_head.rd;
    assign out_wb       = pop_m ? m_head.wb    : l_head.wb;
    assign out_data     = pop_m ? m_head.data  : l_head.data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_seq <= '0;
            wb_cnt  <= ipu_pkg::WB_CNT_BITS'(ipu_pkg::WB_CREDITS);
        end else begin
            if (out_valid) begin
                exp_seq <= exp_seq + 1'b1;
            end
            case ({wb_credit, out_valid})
                2'b10:   wb_cnt <= wb_cnt + 1'b1;
                2'b01:   wb_cnt <= wb_cnt - 1'b1;
                default: wb_cnt <= wb_cnt;
            endcase
        end
    end

    // dispatch hands out each tag once within the credit window
    a_unique_heads: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(!m_empty && !l_empty && m_head.seq == l_head.seq)
    );

endmodule

/* hdl/ipu_fifo.sv */
// result FIFO
module ipu_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,
    output logic empty,
    output logic full
);

    T mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] cnt;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

    assign head  = mem[rd_ptr];  // valid the cycle after the push
    assign empty = (cnt == '0);
    assign full  = (int'(cnt) == DEPTH);

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);

endmodule

/* hdl/ipu_lerp.sv */
// fixed-point linear interpolation pipeline
module ipu_lerp (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    input  logic [ipu_pkg::SEQ_BITS-1:0]  req_seq,
    input  logic [ipu_pkg::NW_BITS-1:0]   req_wid,
    input  logic [ipu_pkg::NUM_LANES-1:0] req_tmask,
    input  logic [ipu_pkg::NR_BITS-1:0]   req_rd,
    input  logic                          req_wb,
    input  ipu_pkg::lane_data_t           a,
    input  ipu_pkg::lane_data_t           b,
    input  ipu_pkg::lane_data_t           c,
    output logic                          res_valid,
    output ipu_pkg::lerp_res_t            res
);

    logic [ipu_pkg::LAT_LERP-1:0] vld_q;

    ipu_pkg::lerp_res_t meta_d;
    ipu_pkg::lerp_res_t meta_q [ipu_pkg::LAT_LERP];

    logic [ipu_pkg::NUM_LANES-1:0][47:0] prod_d;
    logic [ipu_pkg::NUM_LANES-1:0][47:0] prod_q [ipu_pkg::LAT_LERP];

    // operand a is carried along in the data field
    assign meta_d = '{
        seq:     req_seq,
        wid:     req_wid,
        tmask:   req_tmask,
        rd:      req_rd,
        wb:      req_wb,
        sat_ign: 1'b0,
        data:    a
    };

    for (genvar i = 0; i < ipu_pkg::NUM_LANES; i++) begin : g_lane
        logic signed [31:0] diff;
        logic signed [48:0] wide;
        assign diff      = $signed(b[i] - a[i]);
        assign wide      = diff * $signed({1'b0, c[i][15:0]});  // t is unsigned Q0.16
        assign prod_d[i] = wide[47:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req_valid;
            for (int s = 1; s < ipu_pkg::LAT_LERP; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            meta_q[0] <= meta_d;
            prod_q[0] <= prod_d;
        end
        for (int s = 1; s < ipu_pkg::LAT_LERP; s++) begin
            if (vld_q[s-1]) begin
                meta_q[s] <= meta_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign res_valid = vld_q[ipu_pkg::LAT_LERP-1];

    // bits 47:16 are the low word of the product shifted right arithmetically by 16
    always_comb begin
        res = meta_q[ipu_pkg::LAT_LERP-1];
        for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
            res.data[i] = meta_q[ipu_pkg::LAT_LERP-1].data[i]
                        + prod_q[ipu_pkg::LAT_LERP-1][i][47:16];
        end
    end

endmodule

/* hdl/ipu_imadd.sv */
// integer multiply-add pipeline
module ipu_imadd (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          req_valid,
    input  logic                          req_hi,
    input  logic [ipu_pkg::SEQ_BITS-1:0]  req_seq,
    input  logic [ipu_pkg::NW_BITS-1:0]   req_wid,
    input  logic [ipu_pkg::NUM_LANES-1:0] req_tmask,
    input  logic [ipu_pkg::NR_BITS-1:0]   req_rd,
    input  logic                          req_wb,
    input  ipu_pkg::lane_data_t           a,
    input  ipu_pkg::lane_data_t           b,
    input  ipu_pkg::lane_data_t           c,
    output logic                          res_valid,
    output ipu_pkg::imadd_res_t           res
);

    logic [ipu_pkg::LAT_IMADD-1:0] vld_q;
    logic [ipu_pkg::LAT_IMADD-1:0] hi_q;

    ipu_pkg::imadd_res_t meta_d;
    ipu_pkg::imadd_res_t meta_q [ipu_pkg::LAT_IMADD];

    logic [ipu_pkg::NUM_LANES-1:0][63:0] prod_d;
    logic [ipu_pkg::NUM_LANES-1:0][63:0] prod_q [ipu_pkg::LAT_IMADD];

    // the addend rides in the data field until the final add
    assign meta_d = '{
        seq:   req_seq,
        wid:   req_wid,
        tmask: req_tmask,
        rd:    req_rd,
        wb:    req_wb,
        data:  c
    };

    always_comb begin
        for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
            prod_d[i] = 64'(a[i]) * 64'(b[i]);  // full unsigned product
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= req_valid;
            for (int s = 1; s < ipu_pkg::LAT_IMADD; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            hi_q[0]   <= req_hi;
            meta_q[0] <= meta_d;
            prod_q[0] <= prod_d;
        end
        for (int s = 1; s < ipu_pkg::LAT_IMADD; s++) begin
            if (vld_q[s-1]) begin
                hi_q[s]   <= hi_q[s-1];
                meta_q[s] <= meta_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign res_valid = vld_q[ipu_pkg::LAT_IMADD-1];

    always_comb begin
        res = meta_q[ipu_pkg::LAT_IMADD-1];
        for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
            res.data[i] = (hi_q[ipu_pkg::LAT_IMADD-1] ? prod_q[ipu_pkg::LAT_IMADD-1][i][63:32]
                                                      : prod_q[ipu_pkg::LAT_IMADD-1][i][31:0])
                        + meta_q[ipu_pkg::LAT_IMADD-1].data[i];  // wraps at 32 bits
        end
    end

endmodule

/* hdl/ipu_dispatch.sv */
// request dispatch and tagging
module ipu_dispatch (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         in_valid,
    input  logic [ipu_pkg::OP_BITS-1:0]  in_op,
    input  logic                         credit_ret,
    output logic                         imadd_valid,
    output logic                         imadd_hi,
    output logic                         lerp_valid,
    output logic [ipu_pkg::SEQ_BITS-1:0] seq
);

    logic [ipu_pkg::FLIGHT_BITS-1:0] inflight;
    logic                            is_mul;

    assign is_mul      = (in_op == ipu_pkg::OP_MUL_LO) || (in_op == ipu_pkg::OP_MUL_HI);
    assign imadd_valid = in_valid && is_mul;
    assign imadd_hi    = (in_op == ipu_pkg::OP_MUL_HI);
    assign lerp_valid  = in_valid && (in_op == ipu_pkg::OP_LERP);

    // every request is accepted because credits keep the units from ever stalling
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seq <= '0;
        end else if (in_valid) begin
            seq <= seq + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inflight <= '0;
        end else begin
            case ({in_valid, credit_ret})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;  // accept and return cancel out
            endcase
        end
    end

    // the issuer must not run ahead of the credits it was given
    a_inflight_bound: assert property (
        @(posedge clk) disable iff (!arst_n) int'(inflight) <= ipu_pkg::ISSUE_CREDITS
    );

    a_known_op: assert property (
        @(posedge clk) disable iff (!arst_n)
        in_valid |-> (is_mul || in_op == ipu_pkg::OP_LERP)
    );

endmodule

/* hdl/ipu_pkg.sv */
// interpolation unit shared definitions
package ipu_pkg;

    localparam int NUM_LANES = 4;
    localparam int NW_BITS   = 3;
    localparam int NR_BITS   = 5;
    localparam int SEQ_BITS  = 4;

    localparam int ISSUE_CREDITS = 8;  // stays below 2**SEQ_BITS so live tags are unique
    localparam int WB_CREDITS    = 2;
    localparam int FLIGHT_BITS   = $clog2(ISSUE_CREDITS + 1);
    localparam int WB_CNT_BITS   = $clog2(WB_CREDITS + 1);

    localparam int LAT_IMADD = 3;
    localparam int LAT_LERP  = 2;

    localparam int OP_BITS = 2;
    localparam logic [OP_BITS-1:0] OP_MUL_LO = 2'd0;
    localparam logic [OP_BITS-1:0] OP_MUL_HI = 2'd1;
    localparam logic [OP_BITS-1:0] OP_LERP   = 2'd2;

    typedef logic [NUM_LANES-1:0][31:0] lane_data_t;

    typedef struct packed {
        logic [SEQ_BITS-1:0]  seq;
        logic [NW_BITS-1:0]   wid;
        logic [NUM_LANES-1:0] tmask;
        logic [NR_BITS-1:0]   rd;
        logic                 wb;
        lane_data_t           data;
    } imadd_res_t;

    // same fields as the multiply-add result with one spare flag
    typedef struct packed {
        logic [SEQ_BITS-1:0]  seq;
        logic [NW_BITS-1:0]   wid;
        logic [NUM_LANES-1:0] tmask;
        logic [NR_BITS-1:0]   rd;
        logic                 wb;
        logic                 sat_ign;  // saturation is not applied yet
        lane_data_t           data;
    } lerp_res_t;

endpackage
